// File: mem_types_pkg.sv
package mem_types_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [1:0]  size_t;

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // Widest word index in a line, enough for 8-word lines
    localparam int LINE_IDX_MAX = 3;

    // Segment codes in the top three address bits
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    typedef union packed {
        struct packed {
            logic [2:0]  seg;
            logic [28:0] rest;
        } seg_view;
        struct packed {
            logic [29-LINE_IDX_MAX:0] tag;
            logic [LINE_IDX_MAX-1:0]  idx;   // Buffers use only the low bits they need
            logic [1:0]               off;
        } line_view;
    } paddr_u;

endpackage

// File: mem_bus_pkg.sv
package mem_bus_pkg;

    // Core side, req/addr_ok/data_ok handshake
    typedef struct packed {
        logic                 req;
        logic                 wr;
        mem_types_pkg::size_t size;
        mem_types_pkg::addr_t addr;
        mem_types_pkg::word_t wdata;   // Byte lanes follow the address offset
    } sramx_req_t;

    typedef struct packed {
        logic                 addr_ok;
        logic                 data_ok;
        mem_types_pkg::word_t rdata;
    } sramx_resp_t;

    // Single-word four-phase req/ack bus
    typedef struct packed {
        logic                 req;
        logic                 wr;
        mem_types_pkg::size_t size;
        mem_types_pkg::addr_t addr;
        mem_types_pkg::word_t wdata;
    } wbus_req_t;

    typedef struct packed {
        logic                 ack;
        mem_types_pkg::word_t rdata;   // Valid while ack is high
    } wbus_resp_t;

endpackage

// File: addr_translator.sv
`timescale 1ns/1ps

module addr_translator (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  mem_bus_pkg::sramx_req_t  imem_req,
    input  mem_bus_pkg::sramx_req_t  dmem_req,
    output mem_bus_pkg::sramx_resp_t imem_resp,
    output mem_bus_pkg::sramx_resp_t dmem_resp,
    output mem_bus_pkg::sramx_req_t  icached_req,
    input  mem_bus_pkg::sramx_resp_t icached_resp,
    output mem_bus_pkg::sramx_req_t  dcached_req,
    input  mem_bus_pkg::sramx_resp_t dcached_resp,
    output mem_bus_pkg::sramx_req_t  uncached_req,
    input  mem_bus_pkg::sramx_resp_t uncached_resp
);
    import mem_types_pkg::*;

    paddr_u d_vaddr;
    logic   d_uncached;     // Current data request targets kseg1
    logic   owner_unc;      // Path that accepted the outstanding data request

    // kseg0 and kseg1 both map onto the low 512 MB
    function automatic addr_t translate(addr_t vaddr);
        paddr_u pa;
        pa = vaddr;
        if (pa.seg_view.seg == SEG_KSEG0 || pa.seg_view.seg == SEG_KSEG1) begin
            pa.seg_view.seg = 3'b000;
        end
        return pa;
    endfunction

    assign d_vaddr    = dmem_req.addr;
    assign d_uncached = (d_vaddr.seg_view.seg == SEG_KSEG1);

    always_comb begin
        // Instruction fetches always go through the buffer
        icached_req      = imem_req;
        icached_req.addr = translate(imem_req.addr);
        imem_resp        = icached_resp;

        dcached_req      = dmem_req;
        dcached_req.addr = translate(dmem_req.addr);
        dcached_req.req  = dmem_req.req & ~d_uncached;
        uncached_req     = dcached_req;
        uncached_req.req = dmem_req.req & d_uncached;

        dmem_resp.addr_ok = d_uncached ? uncached_resp.addr_ok : dcached_resp.addr_ok;
        dmem_resp.data_ok = owner_unc ? uncached_resp.data_ok : dcached_resp.data_ok;
        dmem_resp.rdata   = owner_unc ? uncached_resp.rdata : dcached_resp.rdata;
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            owner_unc <= 1'b0;
        end else if (dmem_resp.addr_ok) begin
            owner_unc <= d_uncached;
        end
    end

endmodule

// File: line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
    parameter int LINE_WORDS = 4
) (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  mem_bus_pkg::sramx_req_t  sramx_req,
    output mem_bus_pkg::sramx_resp_t sramx_resp,
    output mem_bus_pkg::wbus_req_t   wbus_req,
    input  mem_bus_pkg::wbus_resp_t  wbus_resp
);
    import mem_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int         IDX_BITS = $clog2(LINE_WORDS);
    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_REQ    = 2'd1;   // Word-bus req high, waiting for ack
    localparam logic [1:0] S_REL    = 2'd2;   // Req dropped, waiting for ack to fall

    logic [1:0]           state_q;
    logic                 valid_q;
    logic                 fill_q;
    logic [IDX_BITS-1:0]  cnt_q;
    logic                 data_ok_q;
    logic [29-IDX_BITS:0] tag_q;
    word_t                line_q [LINE_WORDS];
    sramx_req_t           op_q;
    word_t                rdata_q;

    paddr_u               pa;
    logic [29:0]          req_word;
    logic [IDX_BITS-1:0]  req_idx;
    logic                 hit;
    logic                 accept;
    logic                 miss;
    logic [3:0]           be;

    function automatic logic [3:0] byte_en(size_t size, logic [1:0] off);
        case (size)
            SIZE_BYTE: return 4'b0001 << off;
            SIZE_HALF: return 4'b0011 << off;
            default:   return 4'b1111;
        endcase
    endfunction

    assign pa       = sramx_req.addr;
    assign req_word = {pa.line_view.tag, pa.line_view.idx};
    assign req_idx  = pa.line_view.idx[IDX_BITS-1:0];
    assign hit      = valid_q && (tag_q == req_word[29:IDX_BITS]);
    assign accept   = (state_q == S_IDLE) && sramx_req.req && (sramx_req.wr || hit);
    assign miss     = (state_q == S_IDLE) && sramx_req.req && !accept;
    assign be       = byte_en(sramx_req.size, pa.line_view.off);

    assign sramx_resp.addr_ok = accept;
    assign sramx_resp.data_ok = data_ok_q;
    assign sramx_resp.rdata   = rdata_q;

    assign wbus_req.req   = (state_q == S_REQ);
    assign wbus_req.wr    = ~fill_q;
    assign wbus_req.size  = fill_q ? SIZE_WORD : op_q.size;
    assign wbus_req.addr  = fill_q ? {tag_q, cnt_q, 2'b00} : op_q.addr;
    assign wbus_req.wdata = op_q.wdata;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= S_IDLE;
            valid_q   <= 1'b0;
            fill_q    <= 1'b0;
            cnt_q     <= '0;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        data_ok_q <= ~sramx_req.wr;   // Read hit answers next cycle
                        fill_q    <= 1'b0;
                        state_q   <= sramx_req.wr ? S_REQ : S_IDLE;
                    end else if (miss) begin
                        // Line is dropped until the refill has finished
                        valid_q <= 1'b0;
                        fill_q  <= 1'b1;
                        cnt_q   <= '0;
                        state_q <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (wbus_resp.ack) begin
                        state_q <= S_REL;
                    end
                end
                S_REL: begin
                    if (!wbus_resp.ack) begin
                        if (!fill_q) begin
                            data_ok_q <= 1'b1;
                            state_q   <= S_IDLE;
                        end else if (&cnt_q) begin
                            valid_q <= 1'b1;     // The held request now hits in IDLE
                            state_q <= S_IDLE;
                        end else begin
                            cnt_q   <= cnt_q + 1'b1;
                            state_q <= S_REQ;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (miss) begin
            tag_q <= req_word[29:IDX_BITS];
        end
        if (accept) begin
            op_q    <= sramx_req;
            rdata_q <= line_q[req_idx];
        end
        if (accept && sramx_req.wr && hit) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    line_q[req_idx][8*i +: 8] <= sramx_req.wdata[8*i +: 8];
                end
            end
        end
        if (state_q == S_REQ && wbus_resp.ack && fill_q) begin
            line_q[cnt_q] <= wbus_resp.rdata;
        end
    end

endmodule

// File: uncached_port.sv
`timescale 1ns/1ps

module uncached_port (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  mem_bus_pkg::sramx_req_t  sramx_req,
    output mem_bus_pkg::sramx_resp_t sramx_resp,
    output mem_bus_pkg::wbus_req_t   wbus_req,
    input  mem_bus_pkg::wbus_resp_t  wbus_resp
);
    import mem_types_pkg::*;
    import mem_bus_pkg::*;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_REQ  = 2'd1;
    localparam logic [1:0] S_REL  = 2'd2;

    logic [1:0] state_q;
    logic       data_ok_q;
    logic       accept;
    sramx_req_t op_q;
    word_t      rdata_q;

    assign accept = (state_q == S_IDLE) && sramx_req.req;

    assign sramx_resp.addr_ok = accept;
    assign sramx_resp.data_ok = data_ok_q;
    assign sramx_resp.rdata   = rdata_q;

    assign wbus_req.req   = (state_q == S_REQ);
    assign wbus_req.wr    = op_q.wr;
    assign wbus_req.size  = op_q.size;
    assign wbus_req.addr  = op_q.addr;
    assign wbus_req.wdata = op_q.wdata;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= S_IDLE;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= 1'b0;
            case (state_q)
                S_IDLE:  if (accept) state_q <= S_REQ;
                S_REQ:   if (wbus_resp.ack) state_q <= S_REL;
                S_REL: begin
                    if (!wbus_resp.ack) begin
                        data_ok_q <= 1'b1;    // Answer once the handshake is closed
                        state_q   <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            op_q <= sramx_req;
        end
        if (state_q == S_REQ && wbus_resp.ack) begin
            rdata_q <= wbus_resp.rdata;
        end
    end

endmodule

// File: bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  mem_bus_pkg::wbus_req_t  ibuf_req,
    input  mem_bus_pkg::wbus_req_t  dbuf_req,
    input  mem_bus_pkg::wbus_req_t  unc_req,
    output mem_bus_pkg::wbus_resp_t ibuf_resp,
    output mem_bus_pkg::wbus_resp_t dbuf_resp,
    output mem_bus_pkg::wbus_resp_t unc_resp,
    output mem_bus_pkg::wbus_req_t  mem_req,
    input  mem_bus_pkg::wbus_resp_t mem_resp
);
    localparam logic [1:0] G_NONE = 2'd0;
    localparam logic [1:0] G_UNC  = 2'd1;
    localparam logic [1:0] G_DBUF = 2'd2;
    localparam logic [1:0] G_IBUF = 2'd3;

    logic [1:0] grant_q;
    logic [1:0] pick;
    logic [1:0] sel;

    // Uncached first, then data, then instruction
    always_comb begin
        if (unc_req.req) begin
            pick = G_UNC;
        end else if (dbuf_req.req) begin
            pick = G_DBUF;
        end else if (ibuf_req.req) begin
            pick = G_IBUF;
        end else begin
            pick = G_NONE;
        end
    end

    assign sel = (grant_q != G_NONE) ? grant_q : pick;   // New winner passes through at once

    always_comb begin
        case (sel)
            G_UNC:   mem_req = unc_req;
            G_DBUF:  mem_req = dbuf_req;
            G_IBUF:  mem_req = ibuf_req;
            default: mem_req = '0;
        endcase
    end

    assign unc_resp.ack    = (sel == G_UNC) && mem_resp.ack;
    assign unc_resp.rdata  = mem_resp.rdata;
    assign dbuf_resp.ack   = (sel == G_DBUF) && mem_resp.ack;
    assign dbuf_resp.rdata = mem_resp.rdata;
    assign ibuf_resp.ack   = (sel == G_IBUF) && mem_resp.ack;
    assign ibuf_resp.rdata = mem_resp.rdata;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            grant_q <= G_NONE;
        end else if (grant_q == G_NONE) begin
            grant_q <= pick;
        end else if (!mem_req.req && !mem_resp.ack) begin
            grant_q <= G_NONE;   // Both phases of the handshake are back to low
        end
    end

endmodule

// File: cache_layer.sv
`timescale 1ns/1ps

module cache_layer #(
    parameter int LINE_WORDS = 4
) (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  mem_bus_pkg::sramx_req_t  imem_req,
    input  mem_bus_pkg::sramx_req_t  dmem_req,
    output mem_bus_pkg::sramx_resp_t imem_resp,
    output mem_bus_pkg::sramx_resp_t dmem_resp,
    output mem_bus_pkg::wbus_req_t   mem_req,
    input  mem_bus_pkg::wbus_resp_t  mem_resp
);
    import mem_bus_pkg::*;

    sramx_req_t  icached_req,  dcached_req,  uncached_req;
    sramx_resp_t icached_resp, dcached_resp, uncached_resp;
    wbus_req_t   ibuf_wreq,  dbuf_wreq,  unc_wreq;
    wbus_resp_t  ibuf_wresp, dbuf_wresp, unc_wresp;

    addr_translator translator_inst (
        .aclk, .rst_n,
        .imem_req, .dmem_req,
        .imem_resp, .dmem_resp,
        .icached_req, .icached_resp,
        .dcached_req, .dcached_resp,
        .uncached_req, .uncached_resp
    );

    line_buffer #(.LINE_WORDS(LINE_WORDS)) ibuf_inst (
        .aclk, .rst_n,
        .sramx_req(icached_req), .sramx_resp(icached_resp),
        .wbus_req(ibuf_wreq),    .wbus_resp(ibuf_wresp)
    );

    line_buffer #(.LINE_WORDS(LINE_WORDS)) dbuf_inst (
        .aclk, .rst_n,
        .sramx_req(dcached_req), .sramx_resp(dcached_resp),
        .wbus_req(dbuf_wreq),    .wbus_resp(dbuf_wresp)
    );

    uncached_port unc_inst (
        .aclk, .rst_n,
        .sramx_req(uncached_req), .sramx_resp(uncached_resp),
        .wbus_req(unc_wreq),      .wbus_resp(unc_wresp)
    );

    bus_arbiter arbiter_inst (
        .aclk, .rst_n,
        .ibuf_req(ibuf_wreq),   .dbuf_req(dbuf_wreq),   .unc_req(unc_wreq),
        .ibuf_resp(ibuf_wresp), .dbuf_resp(dbuf_wresp), .unc_resp(unc_wresp),
        .mem_req, .mem_resp
    );

endmodule

// File: cache_layer_sva.sv
`timescale 1ns/1ps

module cache_layer_sva (
    input logic                     aclk,
    input logic                     rst_n,
    input mem_bus_pkg::wbus_req_t   mem_req,
    input mem_bus_pkg::wbus_resp_t  mem_resp,
    input mem_bus_pkg::sramx_resp_t imem_resp,
    input mem_bus_pkg::sramx_resp_t dmem_resp
);
    int   assert_fails = 0;
    logic i_pend;     // addr_ok given, data_ok not yet
    logic d_pend;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            i_pend <= 1'b0;
            d_pend <= 1'b0;
        end else begin
            i_pend <= imem_resp.addr_ok | (i_pend & ~imem_resp.data_ok);
            d_pend <= dmem_resp.addr_ok | (d_pend & ~dmem_resp.data_ok);
        end
    end

    req_fields_stable: assert property (@(posedge aclk) disable iff (!rst_n)
            (mem_req.req && !mem_resp.ack) |=> $stable(mem_req))
        else begin
            assert_fails++;
            $error("mem_req changed while waiting for ack");
        end

    no_req_rise_on_ack: assert property (@(posedge aclk) disable iff (!rst_n)
            $rose(mem_req.req) |-> !mem_resp.ack)
        else begin
            assert_fails++;
            $error("mem_req rose while ack was still high");
        end

    imem_data_after_addr: assert property (@(posedge aclk) disable iff (!rst_n)
            imem_resp.data_ok |-> i_pend)
        else begin
            assert_fails++;
            $error("imem data_ok without an earlier addr_ok");
        end

    dmem_data_after_addr: assert property (@(posedge aclk) disable iff (!rst_n)
            dmem_resp.data_ok |-> d_pend)
        else begin
            assert_fails++;
            $error("dmem data_ok without an earlier addr_ok");
        end

endmodule

bind cache_layer cache_layer_sva sva_inst (
    .aclk, .rst_n, .mem_req, .mem_resp, .imem_resp, .dmem_resp
);

// File: cache_layer_checker.sv
`timescale 1ns/1ps

module cache_layer_checker (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  mem_bus_pkg::sramx_req_t  imem_req,
    input  mem_bus_pkg::sramx_req_t  dmem_req,
    input  mem_bus_pkg::sramx_resp_t imem_resp,
    input  mem_bus_pkg::sramx_resp_t dmem_resp,
    input  mem_bus_pkg::wbus_req_t   mem_req,
    input  logic                     test_end,
    input  int                       test_num,
    input  int                       exp_ext,
    output int                       errors
);
    import mem_types_pkg::*;

    word_t       shadow [logic [29:0]];
    logic [29:0] i_word;
    logic [29:0] d_word;
    logic        i_busy;
    logic        d_busy;
    logic        d_wr;
    logic        req_prev;
    int          ext_cnt;
    int          errors_at_start;

    function automatic word_t initial_word(logic [29:0] widx);
        return (widx * 32'h9E37_79B9) ^ {2'b01, widx};
    endfunction

    // kseg0 and kseg1 both lose their top three bits
    function automatic logic [29:0] phys_word(addr_t va);
        return (va[31:30] == 2'b10) ? {3'b000, va[28:2]} : va[31:2];
    endfunction

    function automatic word_t expected(logic [29:0] widx);
        return shadow.exists(widx) ? shadow[widx] : initial_word(widx);
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t wdata, size_t size,
                                          logic [1:0] off);
        word_t r;
        int    nbytes;
        r      = old;
        nbytes = 1 << size;
        for (int b = 0; b < 4; b++) begin
            if (b >= off && b < off + nbytes) r[8*b +: 8] = wdata[8*b +: 8];
        end
        return r;
    endfunction

    initial begin
        errors          = 0;
        errors_at_start = 0;
        ext_cnt         = 0;
    end

    always @(posedge aclk) begin : watch
        if (!rst_n) begin
            i_busy   = 1'b0;
            d_busy   = 1'b0;
            req_prev = 1'b0;
            ext_cnt  = 0;
        end else begin
            if (mem_req.req && !req_prev) begin
                ext_cnt++;
                if (!(imem_req.req || dmem_req.req || i_busy || d_busy)) begin
                    $display("error at %0t: external request with no core request", $time);
                    errors++;
                end
            end
            req_prev = mem_req.req;

            if (imem_resp.data_ok) begin
                if (!i_busy) begin
                    $display("error at %0t: imem data_ok with nothing outstanding", $time);
                    errors++;
                end else if (imem_resp.rdata !== expected(i_word)) begin
                    $display("mismatch at %0t: imem_resp.rdata = %h, expected %h",
                             $time, imem_resp.rdata, expected(i_word));
                    errors++;
                end
                i_busy = 1'b0;
            end
            if (imem_resp.addr_ok) begin
                if (!imem_req.req) begin
                    $display("error at %0t: imem addr_ok without a request", $time);
                    errors++;
                end
                i_word = phys_word(imem_req.addr);
                i_busy = 1'b1;
            end

            if (dmem_resp.data_ok) begin
                if (!d_busy) begin
                    $display("error at %0t: dmem data_ok with nothing outstanding", $time);
                    errors++;
                end else if (!d_wr && dmem_resp.rdata !== expected(d_word)) begin
                    $display("mismatch at %0t: dmem_resp.rdata = %h, expected %h",
                             $time, dmem_resp.rdata, expected(d_word));
                    errors++;
                end
                d_busy = 1'b0;
            end
            if (dmem_resp.addr_ok) begin
                if (!dmem_req.req) begin
                    $display("error at %0t: dmem addr_ok without a request", $time);
                    errors++;
                end
                d_word = phys_word(dmem_req.addr);
                d_wr   = dmem_req.wr;
                d_busy = 1'b1;
                if (dmem_req.wr) begin
                    shadow[d_word] = merge_bytes(expected(d_word), dmem_req.wdata,
                                                 dmem_req.size, dmem_req.addr[1:0]);
                end
            end

            if (test_end) begin
                if (ext_cnt != exp_ext) begin
                    $display("mismatch at %0t: mem_req rises = %0d, expected %0d",
                             $time, ext_cnt, exp_ext);
                    errors++;
                end
                $display("test %0d %s with %0d external transactions", test_num,
                         (errors == errors_at_start) ? "passed" : "failed", ext_cnt);
                ext_cnt         = 0;
                errors_at_start = errors;
            end
        end
    end

endmodule

// File: tb_cache_layer.sv
`timescale 1ns/1ps

module tb_cache_layer;
    import mem_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int         LINE_WORDS = 4;
    localparam int         TIMEOUT    = 300;
    localparam int         NUM_TESTS  = 19;
    localparam logic [1:0] ON_I       = 2'b01;
    localparam logic [1:0] ON_D       = 2'b10;
    localparam logic [1:0] ON_ID      = 2'b11;
    localparam logic [7:0] LW         = 8'(LINE_WORDS);

    typedef struct packed {
        logic [1:0] ports;
        addr_t      iaddr;
        logic       wr;
        size_t      size;
        addr_t      daddr;
        word_t      wdata;
        logic [7:0] exp_ext;
    } test_t;

    // ports, fetch address, wr, size, data address, wdata, external transactions
    test_t tests [NUM_TESTS] = '{
        '{ON_I,  32'h8000_1000, 1'b0, SIZE_WORD, 32'h0,         32'h0,         LW},
        '{ON_I,  32'h8000_1004, 1'b0, SIZE_WORD, 32'h0,         32'h0,         8'd0},
        '{ON_I,  32'h8000_100C, 1'b0, SIZE_WORD, 32'h0,         32'h0,         8'd0},
        '{ON_D,  32'h0,         1'b0, SIZE_WORD, 32'hA000_2040, 32'h0,         8'd1},
        '{ON_D,  32'h0,         1'b0, SIZE_WORD, 32'hA000_2040, 32'h0,         8'd1},
        '{ON_D,  32'h0,         1'b0, SIZE_WORD, 32'h8000_3000, 32'h0,         LW},
        '{ON_D,  32'h0,         1'b1, SIZE_BYTE, 32'h8000_3001, 32'h0000_AB00, 8'd1},
        '{ON_D,  32'h0,         1'b1, SIZE_HALF, 32'h8000_3006, 32'hCDEF_0000, 8'd1},
        '{ON_D,  32'h0,         1'b0, SIZE_WORD, 32'h8000_3000, 32'h0,         8'd0},
        '{ON_D,  32'h0,         1'b0, SIZE_WORD, 32'h8000_3004, 32'h0,         8'd0},
        '{ON_D,  32'h0,         1'b1, SIZE_WORD, 32'hA000_3008, 32'h1234_5678, 8'd1},
        '{ON_D,  32'h0,         1'b0, SIZE_WORD, 32'h8000_4000, 32'h0,         LW},
        '{ON_D,  32'h0,         1'b0, SIZE_WORD, 32'h8000_3008, 32'h0,         LW},
        '{ON_D,  32'h0,         1'b0, SIZE_WORD, 32'h8000_3000, 32'h0,         8'd0},
        '{ON_D,  32'h0,         1'b0, SIZE_WORD, 32'h8000_3004, 32'h0,         8'd0},
        '{ON_ID, 32'h8000_5000, 1'b0, SIZE_WORD, 32'h8000_6004, 32'h0,         8'd2 * LW},
        '{ON_ID, 32'h8000_5008, 1'b0, SIZE_WORD, 32'hA000_7000, 32'h0,         8'd1},
        '{ON_ID, 32'h8000_1000, 1'b1, SIZE_WORD, 32'h8000_6008, 32'h5A5A_C3C3, LW + 8'd1},
        '{ON_D,  32'h0,         1'b0, SIZE_WORD, 32'h8000_6008, 32'h0,         8'd0}
    };

    logic        aclk;
    logic        rst_n;
    sramx_req_t  imem_req;
    sramx_req_t  dmem_req;
    sramx_resp_t imem_resp;
    sramx_resp_t dmem_resp;
    wbus_req_t   mem_req;
    wbus_resp_t  mem_resp;
    logic        test_end;
    int          test_num;
    int          exp_ext;
    int          chk_errors;
    int          timeouts;
    int          tests_run;
    logic [31:0] lfsr_q = 32'd88999;
    word_t       mem [logic [29:0]];

    cache_layer #(.LINE_WORDS(LINE_WORDS)) UUT (
        .aclk, .rst_n, .imem_req, .dmem_req, .imem_resp, .dmem_resp, .mem_req, .mem_resp
    );

    cache_layer_checker checker_inst (
        .aclk, .rst_n, .imem_req, .dmem_req, .imem_resp, .dmem_resp, .mem_req,
        .test_end, .test_num, .exp_ext, .errors(chk_errors)
    );

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    function automatic word_t initial_word(logic [29:0] widx);
        return (widx * 32'h9E37_79B9) ^ {2'b01, widx};
    endfunction

    function automatic word_t read_word(logic [29:0] widx);
        return mem.exists(widx) ? mem[widx] : initial_word(widx);
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t wdata, size_t size,
                                          logic [1:0] off);
        word_t r;
        int    nbytes;
        r      = old;
        nbytes = 1 << size;
        for (int b = 0; b < 4; b++) begin
            if (b >= off && b < off + nbytes) r[8*b +: 8] = wdata[8*b +: 8];
        end
        return r;
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic next_lfsr_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    initial begin : memory_model
        logic [29:0] widx;
        int          delay;
        logic        released;
        mem_resp = '0;
        forever begin
            @(posedge aclk);
            if (rst_n && mem_req.req && !mem_resp.ack) begin
                delay = {next_lfsr_bit(), next_lfsr_bit()};   // 0 to 3 cycles
                repeat (delay) @(posedge aclk);
                widx = mem_req.addr[31:2];
                if (mem_req.wr) begin
                    mem[widx] = merge_bytes(read_word(widx), mem_req.wdata, mem_req.size,
                                            mem_req.addr[1:0]);
                end
                mem_resp.rdata <= read_word(widx);
                mem_resp.ack   <= 1'b1;
                released = 1'b0;
                for (int c = 0; c < TIMEOUT && !released; c++) begin
                    @(posedge aclk);
                    released = !mem_req.req;
                end
                if (!released) begin
                    $display("memory: req was never dropped after ack");
                    timeouts++;
                end
                mem_resp.ack <= 1'b0;
            end
        end
    end

    task automatic issue(input bit on_d, input sramx_req_t rq, input int n);
        logic seen;
        seen = 1'b0;
        @(posedge aclk);
        if (on_d) dmem_req <= rq;
        else imem_req <= rq;
        for (int c = 0; c < TIMEOUT && !seen; c++) begin
            @(posedge aclk);
            seen = on_d ? dmem_resp.addr_ok : imem_resp.addr_ok;
        end
        if (on_d) dmem_req.req <= 1'b0;
        else imem_req.req <= 1'b0;
        if (!seen) begin
            $display("test %0d: timeout waiting for %s addr_ok", n, on_d ? "dmem" : "imem");
            timeouts++;
            return;
        end
        seen = 1'b0;
        for (int c = 0; c < TIMEOUT && !seen; c++) begin
            @(posedge aclk);
            seen = on_d ? dmem_resp.data_ok : imem_resp.data_ok;
        end
        if (!seen) begin
            $display("test %0d: timeout waiting for %s data_ok", n, on_d ? "dmem" : "imem");
            timeouts++;
        end
    endtask

    task automatic run_test(input test_t t, input int n);
        sramx_req_t irq;
        sramx_req_t drq;
        irq = '{req: 1'b1, wr: 1'b0, size: SIZE_WORD, addr: t.iaddr, wdata: '0};
        drq = '{req: 1'b1, wr: t.wr, size: t.size, addr: t.daddr, wdata: t.wdata};
        fork
            if (t.ports[0]) issue(1'b0, irq, n);
            if (t.ports[1]) issue(1'b1, drq, n);
        join
        exp_ext  <= t.exp_ext;
        test_num <= n;
        test_end <= 1'b1;   // Checker closes the test on this edge
        @(posedge aclk);
        test_end <= 1'b0;
    endtask

    initial begin : stimulus
        rst_n     = 1'b0;
        imem_req  = '0;
        dmem_req  = '0;
        test_end  = 1'b0;
        test_num  = 0;
        exp_ext   = 0;
        timeouts  = 0;
        tests_run = 0;
        repeat (8) @(posedge aclk);
        rst_n <= 1'b1;
        repeat (5) @(posedge aclk);   // No port may move before the first request
        for (int n = 0; n < NUM_TESTS && timeouts == 0; n++) begin
            run_test(tests[n], n + 1);
            tests_run++;
        end
        @(posedge aclk);
        @(posedge aclk);
        $display("%0d tests run, %0d check errors, %0d assertion failures, %0d timeouts",
                 tests_run, chk_errors, UUT.sva_inst.assert_fails, timeouts);
        if (chk_errors == 0 && UUT.sva_inst.assert_fails == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: flist.f
mem_types_pkg.sv
mem_bus_pkg.sv
addr_translator.sv
line_buffer.sv
uncached_port.sv
bus_arbiter.sv
cache_layer.sv
cache_layer_sva.sv
cache_layer_checker.sv
tb_cache_layer.sv
